// ==== all.f ====
+incdir+include
verilog/bus_pkg.sv
verilog/bus_arbiter_ctrl.sv
verilog/write_lane_align.sv
verilog/read_lane_align.sv
verilog/clint_timer.sv
verilog/axi_sram.sv
verilog/bus_subsys_top.sv
bench/bus_tb.sv

// ==== bench/bus_tb.sv ====
`timescale 1ns/1ps
`include "bus_map.svh"

module bus_tb;

  // window used by the tests, 16 beats of 64 bits
  localparam int win_bytes = 128;
  localparam int win_words = win_bytes / 4;
  // transactions issued over all tests, sizes the watchdog
  localparam int n_txn = 2 * win_words + 28 + 4 + 3 + 200;
  localparam logic [31:0] mem_base = `BUS_MEM_BASE;
  localparam logic [31:0] rtc_lo = `BUS_RTC_ADDR;
  localparam logic [31:0] rtc_hi = `BUS_RTC_ADDR_UP;

  logic        clk;
  logic        rst;
  logic        ifu_arvalid_i;
  logic [31:0] ifu_araddr_i;
  logic        ifu_rvalid_o;
  logic [31:0] ifu_rdata_o;
  logic        lsu_arvalid_i;
  logic [31:0] lsu_araddr_i;
  logic [7:0]  lsu_rstrb_i;
  logic        lsu_rvalid_o;
  logic [31:0] lsu_rdata_o;
  logic        lsu_wvalid_i;
  logic [31:0] lsu_awaddr_i;
  logic [31:0] lsu_wdata_i;
  logic [7:0]  lsu_wstrb_i;
  logic        lsu_wready_o;

  // byte image of the memory window, updated on each completed store
  logic [7:0]  ref_mem [0:win_bytes-1];

  // outstanding request per requester
  logic        ifu_pend;
  logic [31:0] ifu_addr_q;
  logic        lsu_pend;
  logic [31:0] lsu_addr_q;
  logic        st_pend;
  logic [31:0] st_addr_q;
  logic [31:0] st_data_q;
  logic [3:0]  st_strb_q;

  int unsigned cyc;
  int unsigned ifu_done_cyc;
  int unsigned lsu_done_cyc;
  int unsigned st_done_cyc;
  int unsigned lsu_req_cyc;
  logic [31:0] rtc_val;
  int          errors;
  int          issued;
  int          done_cnt;
  integer      seed;

  bus_subsys_top #(
    .MEM_WORDS (256),
    .STALL_EN  (1'b1)
  ) dut_i (
    .clk           (clk),
    .rst           (rst),
    .ifu_arvalid_i (ifu_arvalid_i),
    .ifu_araddr_i  (ifu_araddr_i),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .ifu_rdata_o   (ifu_rdata_o),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_rstrb_i   (lsu_rstrb_i),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .lsu_rdata_o   (lsu_rdata_o),
    .lsu_wvalid_i  (lsu_wvalid_i),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_wstrb_i   (lsu_wstrb_i),
    .lsu_wready_o  (lsu_wready_o)
  );

  initial
  begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
  end

  // the 32-bit half holding addr, low two bits ignored
  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    logic [31:0] off;
    off = (addr - mem_base) & 32'hffff_fffc;
    return {ref_mem[off+3], ref_mem[off+2], ref_mem[off+1], ref_mem[off]};
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
      errors++;
      $display("ERROR time=%0t %s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  // byte i of the store data lands at address + i
  task automatic merge_store();
    logic [31:0] off;
    off = st_addr_q - mem_base;
    for (int i = 0; i < 4; i++)
      if (st_strb_q[i])
        ref_mem[off+i] = st_data_q[8*i +: 8];
  endtask

  // level held until the pulse, dropped in the following cycle
  task automatic fetch_word(input logic [31:0] addr);
    @(posedge clk);
    #1;
    ifu_araddr_i  = addr;
    ifu_arvalid_i = 1'b1;
    ifu_addr_q    = addr;
    ifu_pend      = 1'b1;
    issued++;
    wait (!ifu_pend);
    @(posedge clk);
    #1;
    ifu_arvalid_i = 1'b0;
  endtask

  task automatic load_word(input logic [31:0] addr);
    @(posedge clk);
    #1;
    lsu_araddr_i  = addr;
    lsu_rstrb_i   = 8'h0f;
    lsu_arvalid_i = 1'b1;
    lsu_addr_q    = addr;
    lsu_req_cyc   = cyc;
    lsu_pend      = 1'b1;
    issued++;
    wait (!lsu_pend);
    @(posedge clk);
    #1;
    lsu_arvalid_i = 1'b0;
  endtask

  task automatic store_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    @(posedge clk);
    #1;
    lsu_awaddr_i = addr;
    lsu_wdata_i  = data;
    lsu_wstrb_i  = {4'h0, strb};
    lsu_wvalid_i = 1'b1;
    st_addr_q    = addr;
    st_data_q    = data;
    st_strb_q    = strb;
    st_pend      = 1'b1;
    issued++;
    wait (!st_pend);
    @(posedge clk);
    #1;
    lsu_wvalid_i = 1'b0;
  endtask

  // outputs are registered, so the falling edge sees them settled
  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (ifu_rvalid_o)
      begin
        if (!ifu_pend)
        begin
          errors++;
          $display("fetch completion pulse at %0t without a pending fetch", $time);
        end
        else
        begin
          check_val("ifu_rdata_o", ref_word(ifu_addr_q), ifu_rdata_o);
          ifu_pend     = 1'b0;
          ifu_done_cyc = cyc;
        end
        // every pulse counts, stray ones included
        done_cnt++;
      end
      if (lsu_rvalid_o)
      begin
        if (!lsu_pend)
        begin
          errors++;
          $display("load completion pulse at %0t without a pending load", $time);
        end
        else
        begin
          // low timer word is checked by the test from two samples
          if (lsu_addr_q == rtc_lo)
            rtc_val = lsu_rdata_o;
          else if (lsu_addr_q == rtc_hi)
            check_val("lsu_rdata_o", 32'h0, lsu_rdata_o);
          else
            check_val("lsu_rdata_o", ref_word(lsu_addr_q), lsu_rdata_o);
          lsu_pend     = 1'b0;
          lsu_done_cyc = cyc;
        end
        done_cnt++;
      end
      if (lsu_wready_o)
      begin
        if (!st_pend)
        begin
          errors++;
          $display("store completion pulse at %0t without a pending store", $time);
        end
        else
        begin
          merge_store();
          st_pend     = 1'b0;
          st_done_cyc = cyc;
        end
        done_cnt++;
      end
    end
  end

  // hang guard, generous per transaction
  initial
  begin
    repeat (200 * n_txn) @(posedge clk);
    $display("watchdog expired at %0t, a request never completed", $time);
    $display("Something failed");
    $finish;
  end

  initial
  begin
    logic [31:0] base_a;
    logic [31:0] data;
    logic [31:0] v1;
    int unsigned c1;
    int unsigned kind;
    int unsigned sel;
    int unsigned off;
    seed          = 32'h20237459;
    rst           = 1'b1;
    cyc           = 0;
    errors        = 0;
    issued        = 0;
    done_cnt      = 0;
    ifu_pend      = 1'b0;
    lsu_pend      = 1'b0;
    st_pend       = 1'b0;
    ifu_arvalid_i = 1'b0;
    ifu_araddr_i  = '0;
    lsu_arvalid_i = 1'b0;
    lsu_araddr_i  = '0;
    lsu_rstrb_i   = '0;
    lsu_wvalid_i  = 1'b0;
    lsu_awaddr_i  = '0;
    lsu_wdata_i   = '0;
    lsu_wstrb_i   = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // full words over the whole window, so no read ever sees an unwritten byte
    for (int w = 0; w < win_words; w++)
      store_word(mem_base + 4 * w, $random(seed), 4'hf);
    for (int w = 0; w < win_words; w++)
      fetch_word(mem_base + 4 * w);

    // bytes at every offset, halves where they stay inside the word
    for (int w = 0; w < 2; w++)
    begin
      base_a = mem_base + 32'h40 + 4 * w;
      for (int o = 0; o < 4; o++)
      begin
        store_word(base_a + o, $random(seed), 4'h1);
        load_word(base_a);
      end
      for (int o = 0; o < 3; o++)
      begin
        store_word(base_a + o, $random(seed), 4'h3);
        load_word(base_a);
      end
    end

    // load beats fetch when both ask in the same cycle
    fork
      fetch_word(mem_base + 32'h10);
      load_word(mem_base + 32'h18);
    join
    if (!(lsu_done_cyc < ifu_done_cyc))
    begin
      errors++;
      $display("fetch completed before the load raised in the same cycle");
    end
    // store beats load, and the load then sees the new word
    fork
      store_word(mem_base + 32'h20, $random(seed), 4'hf);
      load_word(mem_base + 32'h20);
    join
    if (!(st_done_cyc < lsu_done_cyc))
    begin
      errors++;
      $display("load completed before the store raised in the same cycle");
    end

    // timer answers locally in two cycles, counter steps once per cycle
    load_word(rtc_lo);
    check_val("timer load latency", 32'd2, lsu_done_cyc - lsu_req_cyc);
    v1 = rtc_val;
    c1 = lsu_done_cyc;
    repeat ({$random(seed)} % 8) @(posedge clk);
    load_word(rtc_lo);
    check_val("timer load latency", 32'd2, lsu_done_cyc - lsu_req_cyc);
    check_val("mtime delta", lsu_done_cyc - c1, rtc_val - v1);
    load_word(rtc_hi);

    // random mix, one request at a time with short gaps
    for (int n = 0; n < 200; n++)
    begin
      repeat ({$random(seed)} % 3) @(posedge clk);
      kind   = {$random(seed)} % 3;
      base_a = mem_base + 4 * ({$random(seed)} % win_words);
      if (kind == 0)
        fetch_word(base_a);
      else if (kind == 1)
        load_word(base_a);
      else
      begin
        sel  = {$random(seed)} % 3;
        data = $random(seed);
        if (sel == 0)
          store_word(base_a, data, 4'hf);
        else if (sel == 1)
        begin
          off = {$random(seed)} % 3;
          store_word(base_a + off, data, 4'h3);
        end
        else
        begin
          off = {$random(seed)} % 4;
          store_word(base_a + off, data, 4'h1);
        end
      end
    end

    // let a stray extra pulse show up before closing
    repeat (10) @(posedge clk);
    if (done_cnt != issued)
    begin
      errors++;
      $display("%0d requests issued but %0d completions seen", issued, done_cnt);
    end
    $display("%0d errors, %0d requests issued, %0d completed", errors, issued, done_cnt);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// ==== verilog/bus_subsys_top.sv ====
`timescale 1ns/1ps

module bus_subsys_top
  import bus_pkg::*;
#(
  parameter int MEM_WORDS = 256,
  parameter bit STALL_EN  = 1'b1
)(
  input  logic                  clk,
  input  logic                  rst,
  // instruction fetch
  input  logic                  ifu_arvalid_i,
  input  logic [bus_addr_w-1:0] ifu_araddr_i,
  output logic                  ifu_rvalid_o,
  output logic [bus_data_w-1:0] ifu_rdata_o,
  // load
  input  logic                  lsu_arvalid_i,
  input  logic [bus_addr_w-1:0] lsu_araddr_i,
  input  logic [axi_strb_w-1:0] lsu_rstrb_i,
  output logic                  lsu_rvalid_o,
  output logic [bus_data_w-1:0] lsu_rdata_o,
  // store
  input  logic                  lsu_wvalid_i,
  input  logic [bus_addr_w-1:0] lsu_awaddr_i,
  input  logic [bus_data_w-1:0] lsu_wdata_i,
  input  logic [axi_strb_w-1:0] lsu_wstrb_i,
  output logic                  lsu_wready_o
);

  // memory bus
  logic [bus_addr_w-1:0] ar_addr;
  logic                  ar_valid;
  logic                  ar_ready;
  logic [axi_data_w-1:0] r_data;
  logic [1:0]            r_resp;
  logic                  r_valid;
  logic                  r_ready;
  logic [bus_addr_w-1:0] aw_addr;
  logic                  aw_valid;
  logic                  aw_ready;
  logic [axi_data_w-1:0] w_data;
  logic [axi_strb_w-1:0] w_strb;
  logic                  w_valid;
  logic                  w_ready;
  logic [1:0]            b_resp;
  logic                  b_valid;
  logic                  b_ready;
  // timer and read steering
  logic                  clint_rd;
  logic [bus_addr_w-1:0] clint_addr;
  logic                  clint_rvalid;
  logic [bus_data_w-1:0] clint_rdata;
  logic                  rd_capture;
  logic                  rd_lsu;

  bus_arbiter_ctrl arb_i (
    .clk            (clk),
    .rst            (rst),
    .ifu_arvalid_i  (ifu_arvalid_i),
    .ifu_araddr_i   (ifu_araddr_i),
    .lsu_arvalid_i  (lsu_arvalid_i),
    .lsu_araddr_i   (lsu_araddr_i),
    .lsu_rstrb_i    (lsu_rstrb_i),
    .lsu_wvalid_i   (lsu_wvalid_i),
    .lsu_awaddr_i   (lsu_awaddr_i),
    .lsu_wstrb_i    (lsu_wstrb_i),
    .arready_i      (ar_ready),
    .rvalid_i       (r_valid),
    .rresp_i        (r_resp),
    .awready_i      (aw_ready),
    .wready_i       (w_ready),
    .bvalid_i       (b_valid),
    .bresp_i        (b_resp),
    .clint_rvalid_i (clint_rvalid),
    .araddr_o       (ar_addr),
    .arsize_o       (),
    .arvalid_o      (ar_valid),
    .rready_o       (r_ready),
    .awaddr_o       (aw_addr),
    .awsize_o       (),
    .awvalid_o      (aw_valid),
    .wvalid_o       (w_valid),
    .bready_o       (b_ready),
    .clint_rd_o     (clint_rd),
    .clint_addr_o   (clint_addr),
    .rd_capture_o   (rd_capture),
    .rd_lsu_o       (rd_lsu),
    .ifu_rvalid_o   (ifu_rvalid_o),
    .lsu_rvalid_o   (lsu_rvalid_o),
    .lsu_wready_o   (lsu_wready_o)
  );

  // store payload is held by the requester for the whole write
  write_lane_align wr_align_i (
    .awaddr_i (lsu_awaddr_i),
    .wdata_i  (lsu_wdata_i),
    .wstrb_i  (lsu_wstrb_i),
    .wdata_o  (w_data),
    .wstrb_o  (w_strb)
  );

  read_lane_align rd_align_i (
    .clk            (clk),
    .rst            (rst),
    .capture_i      (rd_capture),
    .lsu_sel_i      (rd_lsu),
    .half_i         (ar_addr[2]),
    .rdata_i        (r_data),
    .clint_rvalid_i (clint_rvalid),
    .clint_rdata_i  (clint_rdata),
    .ifu_rdata_o    (ifu_rdata_o),
    .lsu_rdata_o    (lsu_rdata_o)
  );

  clint_timer clint_i (
    .clk      (clk),
    .rst      (rst),
    .rd_i     (clint_rd),
    .addr_i   (clint_addr),
    .rvalid_o (clint_rvalid),
    .rdata_o  (clint_rdata)
  );

  axi_sram #(
    .MEM_WORDS (MEM_WORDS),
    .STALL_EN  (STALL_EN)
  ) sram_i (
    .clk       (clk),
    .rst       (rst),
    .araddr_i  (ar_addr),
    .arvalid_i (ar_valid),
    .arready_o (ar_ready),
    .rdata_o   (r_data),
    .rresp_o   (r_resp),
    .rvalid_o  (r_valid),
    .rready_i  (r_ready),
    .awaddr_i  (aw_addr),
    .awvalid_i (aw_valid),
    .awready_o (aw_ready),
    .wdata_i   (w_data),
    .wstrb_i   (w_strb),
    .wvalid_i  (w_valid),
    .wready_o  (w_ready),
    .bresp_o   (b_resp),
    .bvalid_o  (b_valid),
    .bready_i  (b_ready)
  );

endmodule

// ==== verilog/axi_sram.sv ====
`timescale 1ns/1ps
`include "bus_map.svh"

module axi_sram
  import bus_pkg::*;
#(
  parameter int MEM_WORDS = 256,
  parameter bit STALL_EN  = 1'b1
)(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [bus_addr_w-1:0] araddr_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  output logic [axi_data_w-1:0] rdata_o,
  output logic [1:0]            rresp_o,
  output logic                  rvalid_o,
  input  logic                  rready_i,
  input  logic [bus_addr_w-1:0] awaddr_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,
  input  logic [axi_data_w-1:0] wdata_i,
  input  logic [axi_strb_w-1:0] wstrb_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,
  output logic [1:0]            bresp_o,
  output logic                  bvalid_o,
  input  logic                  bready_i
);

  localparam int idx_w = $clog2(MEM_WORDS);

  logic [axi_data_w-1:0] mem [MEM_WORDS];
  logic [19:0]           lfsr_q;
  logic                  ar_gate;
  logic                  aw_gate;
  logic                  w_gate;
  logic [1:0]            rd_dly;
  logic [1:0]            wr_dly;
  logic [bus_addr_w-1:0] ar_off;
  logic [bus_addr_w-1:0] aw_off;
  logic [idx_w-1:0]      ar_idx;
  logic [idx_w-1:0]      aw_idx;
  logic                  ar_fire;
  logic                  aw_fire;
  logic                  w_fire;
  logic                  wr_busy;
  logic                  wr_commit;
  // read side
  logic                  rd_pend_q;
  logic [1:0]            rd_cnt_q;
  logic [idx_w-1:0]      rd_idx_q;
  logic                  rvalid_q;
  logic [axi_data_w-1:0] rdata_q;
  // write side
  logic                  aw_got_q;
  logic                  w_got_q;
  logic                  b_pend_q;
  logic [1:0]            b_cnt_q;
  logic                  bvalid_q;
  logic [idx_w-1:0]      wr_idx_q;
  logic [axi_data_w-1:0] wdata_q;
  logic [axi_strb_w-1:0] wstrb_q;

  // slow memory model, ready gaps and response delays from the lfsr
  assign ar_gate = STALL_EN ? lfsr_q[19] : 1'b1;
  assign aw_gate = STALL_EN ? lfsr_q[17] : 1'b1;
  assign w_gate  = STALL_EN ? lfsr_q[16] : 1'b1;
  assign rd_dly  = STALL_EN ? lfsr_q[1:0] : 2'd0;
  assign wr_dly  = STALL_EN ? lfsr_q[3:2] : 2'd0;

  // word index inside the window
  assign ar_off = araddr_i - `BUS_MEM_BASE;
  assign aw_off = awaddr_i - `BUS_MEM_BASE;
  assign ar_idx = ar_off[idx_w+2:3];
  assign aw_idx = aw_off[idx_w+2:3];

  // one read and one write at a time
  assign wr_busy   = b_pend_q | bvalid_q;
  assign arready_o = arvalid_i && !rd_pend_q && !rvalid_q && ar_gate;
  assign awready_o = awvalid_i && !aw_got_q && !wr_busy && aw_gate;
  assign wready_o  = wvalid_i && !w_got_q && !wr_busy && w_gate;

  assign ar_fire   = arvalid_i && arready_o;
  assign aw_fire   = awvalid_i && awready_o;
  assign w_fire    = wvalid_i && wready_o;
  assign wr_commit = aw_got_q && w_got_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lfsr_q    <= 20'd1;
      rd_pend_q <= 1'b0;
      rd_cnt_q  <= 2'd0;
      rvalid_q  <= 1'b0;
      aw_got_q  <= 1'b0;
      w_got_q   <= 1'b0;
      b_pend_q  <= 1'b0;
      b_cnt_q   <= 2'd0;
      bvalid_q  <= 1'b0;
    end
    else
    begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[18]};

      // read, rvalid comes 1 to 4 cycles after ar
      if (rvalid_q && rready_i)
        rvalid_q <= 1'b0;
      if (ar_fire)
      begin
        if (rd_dly == 2'd0)
          rvalid_q <= 1'b1;
        else
        begin
          rd_pend_q <= 1'b1;
          rd_cnt_q  <= rd_dly;
        end
      end
      else if (rd_pend_q)
      begin
        if (rd_cnt_q == 2'd1)
        begin
          rd_pend_q <= 1'b0;
          rvalid_q  <= 1'b1;
        end
        else
          rd_cnt_q <= rd_cnt_q - 2'd1;
      end

      // write, commit once both channels are in
      if (bvalid_q && bready_i)
        bvalid_q <= 1'b0;
      if (aw_fire)
        aw_got_q <= 1'b1;
      if (w_fire)
        w_got_q <= 1'b1;
      if (wr_commit)
      begin
        aw_got_q <= 1'b0;
        w_got_q  <= 1'b0;
        b_pend_q <= 1'b1;
        b_cnt_q  <= wr_dly;
      end
      else if (b_pend_q)
      begin
        if (b_cnt_q == 2'd0)
        begin
          b_pend_q <= 1'b0;
          bvalid_q <= 1'b1;
        end
        else
          b_cnt_q <= b_cnt_q - 2'd1;
      end
    end
  end

  // array and beat registers
  always_ff @(posedge clk)
  begin
    if (ar_fire)
      rd_idx_q <= ar_idx;
    if (ar_fire && rd_dly == 2'd0)
      rdata_q <= mem[ar_idx];
    else if (rd_pend_q && rd_cnt_q == 2'd1)
      rdata_q <= mem[rd_idx_q];

    if (aw_fire)
      wr_idx_q <= aw_idx;
    if (w_fire)
    begin
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
    end
    // byte lanes under the strobe
    if (wr_commit)
      for (int b = 0; b < axi_strb_w; b++)
        if (wstrb_q[b])
          mem[wr_idx_q][8*b +: 8] <= wdata_q[8*b +: 8];
  end

  assign rdata_o  = rdata_q;
  assign rresp_o  = resp_okay;
  assign rvalid_o = rvalid_q;
  assign bresp_o  = resp_okay;
  assign bvalid_o = bvalid_q;

  // an empty write beat would be lost silently
  wstrb_live_a: assert property (@(posedge clk) disable iff (rst)
    wvalid_i |-> wstrb_i != '0);

endmodule

// ==== verilog/clint_timer.sv ====
`timescale 1ns/1ps
`include "bus_map.svh"

module clint_timer
  import bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rd_i,
  input  logic [bus_addr_w-1:0] addr_i,
  output logic                  rvalid_o,
  output logic [bus_data_w-1:0] rdata_o
);

  localparam logic [bus_addr_w-1:0] rtc_up = `BUS_RTC_ADDR_UP;

  logic [63:0]           mtime_q;
  logic [63:0]           mtime_nx;
  logic                  rvalid_q;
  logic [bus_data_w-1:0] rdata_q;
  logic                  hi_sel;

  assign mtime_nx = mtime_q + 64'd1;

  // high word shares bit 2 with its address
  assign hi_sel = (addr_i[2] == rtc_up[2]);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime_q  <= '0;
      rvalid_q <= 1'b0;
    end
    else
    begin
      mtime_q  <= mtime_nx;
      rvalid_q <= rd_i;
    end
  end

  // value the counter holds in the answer cycle
  always_ff @(posedge clk)
  begin
    if (rd_i)
      rdata_q <= hi_sel ? mtime_nx[63:32] : mtime_nx[31:0];
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

// ==== verilog/read_lane_align.sv ====
`timescale 1ns/1ps

module read_lane_align
  import bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  capture_i,
  input  logic                  lsu_sel_i,
  input  logic                  half_i,
  input  logic [axi_data_w-1:0] rdata_i,
  input  logic                  clint_rvalid_i,
  input  logic [bus_data_w-1:0] clint_rdata_i,
  output logic [bus_data_w-1:0] ifu_rdata_o,
  output logic [bus_data_w-1:0] lsu_rdata_o
);

  logic [bus_data_w-1:0] word_q;

  // held until the next read completes
  always_ff @(posedge clk)
  begin
    if (rst)
      word_q <= '0;
    else if (clint_rvalid_i)
      word_q <= clint_rdata_i;
    else if (capture_i)
      word_q <= half_i ? rdata_i[63:32] : rdata_i[31:0];
  end

  // only the owner sees the word
  assign lsu_rdata_o = lsu_sel_i ? word_q : '0;
  assign ifu_rdata_o = lsu_sel_i ? '0 : word_q;

endmodule

// ==== verilog/write_lane_align.sv ====
`timescale 1ns/1ps

module write_lane_align
  import bus_pkg::*;
(
  input  logic [bus_addr_w-1:0] awaddr_i,
  input  logic [bus_data_w-1:0] wdata_i,
  input  logic [axi_strb_w-1:0] wstrb_i,
  output logic [axi_data_w-1:0] wdata_o,
  output logic [axi_strb_w-1:0] wstrb_o
);

  logic [1:0]            byte_off;
  logic [bus_data_w-1:0] data_sh;
  logic [axi_strb_w-1:0] strb_sh;

  assign byte_off = awaddr_i[1:0];

  // move the low bytes up to the addressed byte
  assign data_sh = wdata_i << {byte_off, 3'b000};

  // same data in both halves, the strobe picks the live one
  assign wdata_o = {data_sh, data_sh};

  // strobe shifted in a wider field so an overflow stays visible
  assign strb_sh = {4'b0000, wstrb_i[3:0]} << byte_off;

  // bit 2 of the address picks the upper half
  assign wstrb_o = awaddr_i[2] ? {strb_sh[3:0], 4'b0000} : {4'b0000, strb_sh[3:0]};

  // a store never crosses its 32-bit half
  strb_in_half_a: assert final ($isunknown(wstrb_i) || strb_sh[7:4] == 4'b0000);

endmodule

// ==== verilog/bus_arbiter_ctrl.sv ====
`timescale 1ns/1ps
`include "bus_map.svh"

module bus_arbiter_ctrl
  import bus_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  // requesters
  input  logic                  ifu_arvalid_i,
  input  logic [bus_addr_w-1:0] ifu_araddr_i,
  input  logic                  lsu_arvalid_i,
  input  logic [bus_addr_w-1:0] lsu_araddr_i,
  input  logic [axi_strb_w-1:0] lsu_rstrb_i,
  input  logic                  lsu_wvalid_i,
  input  logic [bus_addr_w-1:0] lsu_awaddr_i,
  input  logic [axi_strb_w-1:0] lsu_wstrb_i,
  // memory bus
  input  logic                  arready_i,
  input  logic                  rvalid_i,
  input  logic [1:0]            rresp_i,
  input  logic                  awready_i,
  input  logic                  wready_i,
  input  logic                  bvalid_i,
  input  logic [1:0]            bresp_i,
  input  logic                  clint_rvalid_i,
  output logic [bus_addr_w-1:0] araddr_o,
  output logic [2:0]            arsize_o,
  output logic                  arvalid_o,
  output logic                  rready_o,
  output logic [bus_addr_w-1:0] awaddr_o,
  output logic [2:0]            awsize_o,
  output logic                  awvalid_o,
  output logic                  wvalid_o,
  output logic                  bready_o,
  // timer port
  output logic                  clint_rd_o,
  output logic [bus_addr_w-1:0] clint_addr_o,
  // read data steering
  output logic                  rd_capture_o,
  output logic                  rd_lsu_o,
  // completions
  output logic                  ifu_rvalid_o,
  output logic                  lsu_rvalid_o,
  output logic                  lsu_wready_o
);

  arb_state_t            state_q;
  logic [bus_addr_w-1:0] addr_q;
  logic [2:0]            size_q;
  logic                  owner_lsu_q;
  logic                  arvalid_q;
  logic                  awvalid_q;
  logic                  wvalid_q;
  logic                  ifu_done_q;
  logic                  lsu_done_q;
  logic                  st_done_q;
  logic                  clint_hit;
  logic                  pulse_busy;
  logic                  can_grant;
  logic                  grant_wr;
  logic                  grant_ld;
  logic                  grant_if;
  logic                  aw_fire;
  logic                  w_fire;

  // loads of the two timer words stay off the bus
  assign clint_hit = (lsu_araddr_i == `BUS_RTC_ADDR) || (lsu_araddr_i == `BUS_RTC_ADDR_UP);

  // requester still holds its level while the completion pulse is out
  assign pulse_busy = ifu_done_q | lsu_done_q | st_done_q;
  assign can_grant  = (state_q == st_idle) && !pulse_busy;

  // store first, then load, then fetch
  assign grant_wr = can_grant && lsu_wvalid_i;
  assign grant_ld = can_grant && !lsu_wvalid_i && lsu_arvalid_i;
  assign grant_if = can_grant && !lsu_wvalid_i && !lsu_arvalid_i && ifu_arvalid_i;

  assign aw_fire = awvalid_q && awready_i;
  assign w_fire  = wvalid_q && wready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q     <= st_idle;
      owner_lsu_q <= 1'b0;
      arvalid_q   <= 1'b0;
      awvalid_q   <= 1'b0;
      wvalid_q    <= 1'b0;
      ifu_done_q  <= 1'b0;
      lsu_done_q  <= 1'b0;
      st_done_q   <= 1'b0;
    end
    else
    begin
      // completion strobes last one cycle
      ifu_done_q <= 1'b0;
      lsu_done_q <= 1'b0;
      st_done_q  <= 1'b0;
      case (state_q)
        st_idle:
        begin
          if (grant_wr)
          begin
            awvalid_q <= 1'b1;
            wvalid_q  <= 1'b1;
            state_q   <= st_wr_addr;
          end
          else if (grant_ld && clint_hit)
          begin
            owner_lsu_q <= 1'b1;
            state_q     <= st_clint;
          end
          else if (grant_ld)
          begin
            owner_lsu_q <= 1'b1;
            arvalid_q   <= 1'b1;
            state_q     <= st_rd_addr;
          end
          else if (grant_if)
          begin
            owner_lsu_q <= 1'b0;
            arvalid_q   <= 1'b1;
            state_q     <= st_rd_addr;
          end
        end
        st_rd_addr:
        begin
          if (arready_i)
          begin
            arvalid_q <= 1'b0;
            state_q   <= st_rd_data;
          end
        end
        st_rd_data:
        begin
          if (rvalid_i)
          begin
            ifu_done_q <= !owner_lsu_q;
            lsu_done_q <= owner_lsu_q;
            state_q    <= st_idle;
          end
        end
        st_wr_addr:
        begin
          // aw and w may complete in either order
          if (aw_fire)
            awvalid_q <= 1'b0;
          if (w_fire)
            wvalid_q <= 1'b0;
          if ((aw_fire || !awvalid_q) && (w_fire || !wvalid_q))
            state_q <= st_wr_resp;
        end
        st_wr_resp:
        begin
          if (bvalid_i)
          begin
            st_done_q <= 1'b1;
            state_q   <= st_idle;
          end
        end
        st_clint:
        begin
          if (clint_rvalid_i)
          begin
            lsu_done_q <= 1'b1;
            state_q    <= st_idle;
          end
        end
        default:
          state_q <= st_idle;
      endcase
    end
  end

  // winner's address and access size, held for the whole transaction
  always_ff @(posedge clk)
  begin
    if (grant_wr)
    begin
      addr_q <= lsu_awaddr_i;
      size_q <= size_from_strb(lsu_wstrb_i);
    end
    else if (grant_ld)
    begin
      addr_q <= lsu_araddr_i;
      size_q <= size_from_strb(lsu_rstrb_i);
    end
    else if (grant_if)
    begin
      addr_q <= ifu_araddr_i;
      size_q <= size_from_strb(8'h0f);
    end
  end

  assign araddr_o  = addr_q;
  assign arsize_o  = size_q;
  assign arvalid_o = arvalid_q;
  assign rready_o  = 1'b1;
  assign awaddr_o  = addr_q;
  assign awsize_o  = size_q;
  assign awvalid_o = awvalid_q;
  assign wvalid_o  = wvalid_q;
  assign bready_o  = 1'b1;

  // timer read goes out in the grant cycle itself
  assign clint_rd_o   = grant_ld && clint_hit;
  assign clint_addr_o = lsu_araddr_i;

  assign rd_capture_o = (state_q == st_rd_data) && rvalid_i;
  assign rd_lsu_o     = owner_lsu_q;

  assign ifu_rvalid_o = ifu_done_q;
  assign lsu_rvalid_o = lsu_done_q;
  assign lsu_wready_o = st_done_q;

  // the memory never answers with an error
  rresp_okay_a: assert property (@(posedge clk) disable iff (rst)
    rvalid_i && rready_o |-> rresp_i == resp_okay);
  bresp_okay_a: assert property (@(posedge clk) disable iff (rst)
    bvalid_i && bready_o |-> bresp_i == resp_okay);

  // reads and writes never overlap on the bus
  ar_aw_excl_a: assert property (@(posedge clk) disable iff (rst)
    !(arvalid_o && awvalid_o));

  // ar channel holds until the slave takes it
  ar_hold_a: assert property (@(posedge clk) disable iff (rst)
    arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o));

endmodule

// ==== verilog/bus_pkg.sv ====
package bus_pkg;

  // requester side widths
  localparam int bus_addr_w = 32;
  localparam int bus_data_w = 32;

  // memory bus beat
  localparam int axi_data_w = 64;
  localparam int axi_strb_w = 8;

  localparam logic [1:0] resp_okay = 2'b00;

  // one transaction in flight, so one state covers the whole bus
  typedef enum logic [2:0] {
    st_idle,
    st_rd_addr,
    st_rd_data,
    st_wr_addr,
    st_wr_resp,
    st_clint
  } arb_state_t;

  // byte, half or word access, from the requester strobe
  function automatic logic [2:0] size_from_strb(input logic [axi_strb_w-1:0] strb);
    case (strb)
      8'h01: return 3'd0;
      8'h03: return 3'd1;
      8'h0f: return 3'd2;
      // anything else is treated as a full word
      default: return 3'd2;
    endcase
  endfunction

endpackage

// ==== include/bus_map.svh ====
`ifndef BUS_MAP_SVH
`define BUS_MAP_SVH

// machine timer, low word then high word
// bit 2 tells the two words apart
`define BUS_RTC_ADDR    32'h0200_bff8
`define BUS_RTC_ADDR_UP 32'h0200_bffc

// first byte of the window served by the local memory
`define BUS_MEM_BASE    32'h8000_0000

`endif
